//--- src/miss_cfg_pkg.sv
package miss_cfg_pkg;

  ////////////////////
  // address layout
  ////////////////////

  // physical address width
  localparam int unsigned PADDR_WIDTH  = 56;
  // byte offset inside one cacheline
  localparam int unsigned OFFSET_WIDTH = 4;
  // set index sits right above the offset
  localparam int unsigned INDEX_WIDTH  = 8;
  // everything above offset and index is tag
  localparam int unsigned TAG_WIDTH    = PADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

  ////////////////////
  // cache geometry
  ////////////////////

  // number of ways per set
  localparam int unsigned SET_ASSOC  = 4;
  // binary way index
  localparam int unsigned WAY_WIDTH  = $clog2(SET_ASSOC);
  // one full cacheline in bits
  localparam int unsigned LINE_WIDTH = 128;
  // one set per index value
  localparam int unsigned NUM_SETS   = 1 << INDEX_WIDTH;

  // transaction id carried to memory and back
  localparam int unsigned TID_WIDTH  = 2;

endpackage

//--- src/miss_msg_pkg.sv
package miss_msg_pkg;

  import miss_cfg_pkg::*;

  ////////////////////
  // encodings
  ////////////////////

  // kind of an outgoing memory request
  typedef enum logic {
    MEM_LOAD_REQ,
    MEM_STORE_REQ
  } mem_rtype_e;

  // kind of a memory response
  typedef enum logic {
    RTRN_LOAD_ACK,
    RTRN_STORE_ACK
  } rtrn_type_e;

  ////////////////////
  // messages
  ////////////////////

  // one miss as presented by a load or store port
  typedef struct packed {
    logic [PADDR_WIDTH-1:0] paddr;
    logic [2:0]             size;
    logic [TID_WIDTH-1:0]   tid;
    logic                   nc;
    logic [63:0]            wdata;
    logic [SET_ASSOC-1:0]   vld_bits;
  } miss_req_t;

  // request on the shared memory bus
  typedef struct packed {
    mem_rtype_e             rtype;
    logic [PADDR_WIDTH-1:0] paddr;
    logic [2:0]             size;
    logic [TID_WIDTH-1:0]   tid;
    logic                   nc;
    // refill way, only meaningful for loads
    logic [WAY_WIDTH-1:0]   way;
    logic [63:0]            data;
  } mem_req_t;

  // response from memory, loads always return a whole line
  typedef struct packed {
    rtrn_type_e             rtype;
    logic [TID_WIDTH-1:0]   tid;
    logic [LINE_WIDTH-1:0]  data;
  } mem_rtrn_t;

  // full cacheline write into the cache memory
  typedef struct packed {
    logic                   vld;
    logic [SET_ASSOC-1:0]   we;
    logic [INDEX_WIDTH-1:0] idx;
    logic [TAG_WIDTH-1:0]   tag;
    logic [LINE_WIDTH-1:0]  data;
    logic [SET_ASSOC-1:0]   vld_bits;
  } cl_wr_t;

endpackage

//--- src/refill_way_sel.sv
`timescale 1ns/100ps

module refill_way_sel import miss_cfg_pkg::*; #(
  parameter logic [7:0] LfsrSeed = 8'h5a
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [SET_ASSOC-1:0] vld_bits_i,
  input  logic                 advance_i,
  output logic [WAY_WIDTH-1:0] way_o
);

  logic [7:0]           lfsr_q;
  logic [WAY_WIDTH-1:0] inv_way;
  logic                 all_vld;

  // lowest invalid way wins, scan from the top down
  always_comb begin
    inv_way = '0;
    for (int i = SET_ASSOC - 1; i >= 0; i--) begin
      if (!vld_bits_i[i]) begin
        inv_way = WAY_WIDTH'(i);
      end
    end
  end

  assign all_vld = &vld_bits_i;

  // set full: evict a pseudo random way
  assign way_o = all_vld ? lfsr_q[WAY_WIDTH-1:0] : inv_way;

  // maximal length taps x^8 + x^6 + x^5 + x^4 + 1
  // only steps when a random victim was really used
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= LfsrSeed;
    end else if (advance_i) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

endmodule

//--- src/load_mshr.sv
`timescale 1ns/100ps

module load_mshr import miss_cfg_pkg::*; import miss_msg_pkg::*; #(
  parameter int unsigned NumPorts = 3,
  parameter logic [7:0]  LfsrSeed = 8'h5a
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // read ports
  input  logic      [NumPorts-2:0]              req_i,
  input  miss_req_t [NumPorts-2:0]              miss_i,
  output logic      [NumPorts-2:0]              ack_o,
  output logic      [NumPorts-2:0]              rtrn_vld_o,
  // towards the arbiter
  output logic                                  mem_req_o,
  output mem_req_t                              mem_data_o,
  input  logic                                  grant_ack_i,
  // memory responses
  input  logic                                  rtrn_vld_i,
  input  mem_rtrn_t                             rtrn_i,
  // MSHR state for store collisions and flush
  output logic                                  mshr_vld_o,
  output logic [PADDR_WIDTH-OFFSET_WIDTH-1:0]   mshr_line_o,
  output cl_wr_t                                cl_wr_o,
  output logic                                  miss_o
);

  localparam int unsigned PortW = (NumPorts > 2) ? $clog2(NumPorts - 1) : 1;

  typedef struct packed {
    logic [PADDR_WIDTH-1:0] paddr;
    logic [TID_WIDTH-1:0]   tid;
    logic                   nc;
    logic [WAY_WIDTH-1:0]   way;
    logic [PortW-1:0]       port;
  } mshr_t;

  mshr_t                mshr_q;
  logic                 mshr_vld_q;
  logic                 lock_q;
  logic [PortW-1:0]     lock_port_q, pick, port;
  logic [WAY_WIDTH-1:0] way;
  logic [SET_ASSOC-1:0] way_oh;
  miss_req_t            sel;
  logic                 load_ack;

  ////////////////////
  // port selection
  ////////////////////

  // lowest requesting read port
  always_comb begin
    pick = '0;
    for (int p = NumPorts - 2; p >= 0; p--) begin
      if (req_i[p]) begin
        pick = PortW'(p);
      end
    end
  end

  // a presented request keeps its port until granted
  assign port = lock_q ? lock_port_q : pick;
  assign sel  = miss_i[port];

  refill_way_sel #(
    .LfsrSeed ( LfsrSeed )
  ) i_way_sel (
    .clk_i      ( clk_i                       ),
    .rst_ni     ( rst_ni                      ),
    .vld_bits_i ( sel.vld_bits                ),
    .advance_i  ( grant_ack_i & (&sel.vld_bits) ),
    .way_o      ( way                         )
  );

  // only load responses for a live MSHR count
  assign load_ack = rtrn_vld_i && (rtrn_i.rtype == RTRN_LOAD_ACK) && mshr_vld_q;

  // single MSHR, a response in this cycle frees it for the next load
  assign mem_req_o  = (|req_i) && (!mshr_vld_q || load_ack);
  assign mem_data_o = '{rtype: MEM_LOAD_REQ, paddr: sel.paddr, size: sel.size,
                        tid: sel.tid, nc: sel.nc, way: way, data: '0};

  always_comb begin
    ack_o       = '0;
    ack_o[port] = grant_ack_i;
    rtrn_vld_o  = '0;
    rtrn_vld_o[mshr_q.port] = load_ack;
  end

  // allocation of a cacheable line counts as a miss
  assign miss_o = grant_ack_i & ~sel.nc;

  ////////////////////
  // refill write
  ////////////////////

  assign way_oh = SET_ASSOC'(1) << mshr_q.way;

  always_comb begin
    cl_wr_o          = '0;
    cl_wr_o.vld      = load_ack & ~mshr_q.nc;
    cl_wr_o.we       = cl_wr_o.vld ? way_oh : '0;
    cl_wr_o.idx      = mshr_q.paddr[OFFSET_WIDTH +: INDEX_WIDTH];
    cl_wr_o.tag      = mshr_q.paddr[PADDR_WIDTH-1 -: TAG_WIDTH];
    cl_wr_o.data     = rtrn_i.data;
    cl_wr_o.vld_bits = way_oh;
  end

  assign mshr_vld_o  = mshr_vld_q;
  assign mshr_line_o = mshr_q.paddr[PADDR_WIDTH-1:OFFSET_WIDTH];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mshr_vld_q  <= 1'b0;
      lock_q      <= 1'b0;
      lock_port_q <= '0;
    end else begin
      mshr_vld_q  <= grant_ack_i | (mshr_vld_q & ~load_ack);
      lock_q      <= mem_req_o & ~grant_ack_i;
      lock_port_q <= port;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_ack_i) begin
      mshr_q <= '{paddr: sel.paddr, tid: sel.tid, nc: sel.nc, way: way, port: port};
    end
  end

  // memory must answer with the id of the outstanding load
  rtrn_tid_match : assert property (
    @(posedge clk_i) disable iff (!rst_ni) load_ack |-> rtrn_i.tid == mshr_q.tid)
    else $error("load response tid does not match MSHR");

endmodule

//--- src/store_path.sv
`timescale 1ns/100ps

module store_path import miss_cfg_pkg::*; import miss_msg_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // store port
  input  logic                                req_i,
  input  miss_req_t                           miss_i,
  output logic                                ack_o,
  // towards the arbiter
  output logic                                mem_req_o,
  output mem_req_t                            mem_data_o,
  input  logic                                grant_ack_i,
  // memory responses
  input  logic                                rtrn_vld_i,
  input  mem_rtrn_t                           rtrn_i,
  // line held by the load MSHR
  input  logic                                mshr_vld_i,
  input  logic [PADDR_WIDTH-OFFSET_WIDTH-1:0] mshr_line_i,
  output logic                                rtrn_vld_o,
  output logic [TID_WIDTH-1:0]                rtrn_id_o,
  output logic                                stores_idle_o
);

  // enough for the stores the write buffer can have in flight
  localparam int unsigned CntW = 4;

  logic [CntW-1:0] cnt_q;
  logic            collision, st_ack;

  // hold back a store until the refill of its line is done
  assign collision = mshr_vld_i && (miss_i.paddr[PADDR_WIDTH-1:OFFSET_WIDTH] == mshr_line_i);

  assign mem_req_o  = req_i & ~collision;
  assign mem_data_o = '{rtype: MEM_STORE_REQ, paddr: miss_i.paddr, size: miss_i.size,
                        tid: miss_i.tid, nc: miss_i.nc, way: '0, data: miss_i.wdata};
  assign ack_o      = grant_ack_i;

  // store acks come back in order, just forward the id
  assign st_ack     = rtrn_vld_i && (rtrn_i.rtype == RTRN_STORE_ACK);
  assign rtrn_vld_o = st_ack;
  assign rtrn_id_o  = rtrn_i.tid;

  assign stores_idle_o = (cnt_q == '0);

  // stores sent minus stores acknowledged
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (grant_ack_i && !st_ack) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (st_ack && !grant_ack_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // a store ack without a store in flight
  no_underflow : assert property (
    @(posedge clk_i) disable iff (!rst_ni) st_ack |-> cnt_q != '0)
    else $error("store ack with no store in flight");

endmodule

//--- src/mem_req_arbiter.sv
`timescale 1ns/100ps

module mem_req_arbiter import miss_msg_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     hold_i,
  // load MSHR requester
  input  logic     ld_req_i,
  input  mem_req_t ld_data_i,
  // store requester
  input  logic     st_req_i,
  input  mem_req_t st_data_i,
  input  logic     mem_ack_i,
  output logic     ld_ack_o,
  output logic     st_ack_o,
  output logic     busy_o,
  // memory request bus
  output logic     mem_req_o,
  output mem_req_t mem_data_o
);

  typedef enum logic [1:0] {FREE, LOCK_LD, LOCK_ST} arb_state_e;

  arb_state_e state_q, state_d;
  logic       sel_ld;

  always_comb begin
    mem_req_o = 1'b0;
    sel_ld    = 1'b0;
    case (state_q)
      LOCK_LD: begin
        mem_req_o = 1'b1;
        sel_ld    = 1'b1;
      end
      LOCK_ST: begin
        mem_req_o = 1'b1;
      end
      default: begin
        // no new grant while the flush sequencer holds the bus
        if (!hold_i) begin
          mem_req_o = ld_req_i | st_req_i;
          sel_ld    = ld_req_i;
        end
      end
    endcase
  end

  assign mem_data_o = sel_ld ? ld_data_i : st_data_i;
  assign ld_ack_o   = mem_req_o & mem_ack_i & sel_ld;
  assign st_ack_o   = mem_req_o & mem_ack_i & ~sel_ld;
  assign busy_o     = (state_q != FREE);

  // lock onto the owner until memory takes the request
  assign state_d = (mem_req_o && !mem_ack_i) ? (sel_ld ? LOCK_LD : LOCK_ST) : FREE;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FREE;
    end else begin
      state_q <= state_d;
    end
  end

  // both requesters must keep their payload fixed while waiting
  req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_data_o))
    else $error("memory request changed before acknowledge");

endmodule

//--- src/flush_seq.sv
`timescale 1ns/100ps

module flush_seq import miss_cfg_pkg::*; import miss_msg_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   enable_i,
  input  logic   flush_i,
  // outstanding traffic
  input  logic   mshr_vld_i,
  input  logic   stores_idle_i,
  input  logic   arb_busy_i,
  output logic   hold_o,
  output logic   sweeping_o,
  output cl_wr_t cl_wr_o,
  output logic   flush_ack_o,
  output logic   cache_en_o
);

  typedef enum logic [1:0] {IDLE, DRAIN, SWEEP} state_e;

  state_e                 state_q, state_d;
  logic [INDEX_WIDTH-1:0] cnt_q;
  logic                   ack_pend_q, ack_pend_d;
  logic                   en_q, en_d;
  logic                   last_set, drained;

  assign last_set = (cnt_q == INDEX_WIDTH'(NUM_SETS - 1));
  // a locked request has not reached the MSHR or store counter yet
  assign drained  = !mshr_vld_i && stores_idle_i && !arb_busy_i;

  always_comb begin
    state_d     = state_q;
    ack_pend_d  = ack_pend_q;
    // disabling takes effect right away
    en_d        = en_q & enable_i;
    flush_ack_o = 1'b0;
    case (state_q)
      IDLE: begin
        // enabling always goes through a sweep
        if (flush_i || (enable_i && !en_q)) begin
          state_d    = DRAIN;
          ack_pend_d = flush_i;
        end
      end
      DRAIN: begin
        ack_pend_d = ack_pend_q | flush_i;
        if (drained) begin
          state_d = SWEEP;
        end
      end
      SWEEP: begin
        if (last_set) begin
          state_d     = IDLE;
          flush_ack_o = ack_pend_q;
          ack_pend_d  = 1'b0;
          en_d        = enable_i;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign hold_o     = (state_q != IDLE);
  assign sweeping_o = (state_q == SWEEP);
  assign cache_en_o = en_q;

  // one set per cycle, all ways cleared
  always_comb begin
    cl_wr_o     = '0;
    cl_wr_o.vld = sweeping_o;
    cl_wr_o.we  = {SET_ASSOC{sweeping_o}};
    cl_wr_o.idx = cnt_q;
  end

  // reset starts with a sweep of the whole cache
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= SWEEP;
      cnt_q      <= '0;
      ack_pend_q <= 1'b0;
      en_q       <= 1'b0;
    end else begin
      state_q    <= state_d;
      cnt_q      <= sweeping_o ? cnt_q + 1'b1 : '0;
      ack_pend_q <= ack_pend_d;
      en_q       <= en_d;
    end
  end

endmodule

//--- src/dcache_miss_unit.sv
`timescale 1ns/100ps

module dcache_miss_unit import miss_cfg_pkg::*; import miss_msg_pkg::*; #(
  parameter int unsigned NumPorts = 3,
  parameter logic [7:0]  LfsrSeed = 8'h5a
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // cache management
  input  logic                      enable_i,
  input  logic                      flush_i,
  output logic                      flush_ack_o,
  output logic                      cache_en_o,
  output logic                      miss_o,
  // miss ports, the last one carries stores
  input  logic      [NumPorts-1:0]  miss_req_i,
  input  miss_req_t [NumPorts-1:0]  miss_i,
  output logic      [NumPorts-1:0]  miss_ack_o,
  output logic      [NumPorts-1:0]  miss_rtrn_vld_o,
  output logic [TID_WIDTH-1:0]      miss_rtrn_id_o,
  // cacheline write port
  output cl_wr_t                    wr_cl_o,
  // memory bus
  output logic                      mem_req_o,
  output mem_req_t                  mem_data_o,
  input  logic                      mem_ack_i,
  input  logic                      mem_rtrn_vld_i,
  input  mem_rtrn_t                 mem_rtrn_i
);

  logic                                ld_req, st_req, ld_grant, st_grant;
  mem_req_t                            ld_data, st_data;
  logic                                mshr_vld, stores_idle, arb_busy;
  logic [PADDR_WIDTH-OFFSET_WIDTH-1:0] mshr_line;
  logic                                hold, sweeping;
  cl_wr_t                              ld_cl_wr, fl_cl_wr;
  logic [NumPorts-2:0]                 ld_ack, ld_rtrn_vld;
  logic                                st_ack, st_rtrn_vld;

  load_mshr #(
    .NumPorts ( NumPorts ),
    .LfsrSeed ( LfsrSeed )
  ) i_load_mshr (
    .clk_i       ( clk_i                     ),
    .rst_ni      ( rst_ni                    ),
    .req_i       ( miss_req_i[NumPorts-2:0]  ),
    .miss_i      ( miss_i[NumPorts-2:0]      ),
    .ack_o       ( ld_ack                    ),
    .rtrn_vld_o  ( ld_rtrn_vld               ),
    .mem_req_o   ( ld_req                    ),
    .mem_data_o  ( ld_data                   ),
    .grant_ack_i ( ld_grant                  ),
    .rtrn_vld_i  ( mem_rtrn_vld_i            ),
    .rtrn_i      ( mem_rtrn_i                ),
    .mshr_vld_o  ( mshr_vld                  ),
    .mshr_line_o ( mshr_line                 ),
    .cl_wr_o     ( ld_cl_wr                  ),
    .miss_o      ( miss_o                    )
  );

  store_path i_store_path (
    .clk_i         ( clk_i                  ),
    .rst_ni        ( rst_ni                 ),
    .req_i         ( miss_req_i[NumPorts-1] ),
    .miss_i        ( miss_i[NumPorts-1]     ),
    .ack_o         ( st_ack                 ),
    .mem_req_o     ( st_req                 ),
    .mem_data_o    ( st_data                ),
    .grant_ack_i   ( st_grant               ),
    .rtrn_vld_i    ( mem_rtrn_vld_i         ),
    .rtrn_i        ( mem_rtrn_i             ),
    .mshr_vld_i    ( mshr_vld               ),
    .mshr_line_i   ( mshr_line              ),
    .rtrn_vld_o    ( st_rtrn_vld            ),
    .rtrn_id_o     ( miss_rtrn_id_o         ),
    .stores_idle_o ( stores_idle            )
  );

  mem_req_arbiter i_arbiter (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .hold_i     ( hold       ),
    .ld_req_i   ( ld_req     ),
    .ld_data_i  ( ld_data    ),
    .st_req_i   ( st_req     ),
    .st_data_i  ( st_data    ),
    .mem_ack_i  ( mem_ack_i  ),
    .ld_ack_o   ( ld_grant   ),
    .st_ack_o   ( st_grant   ),
    .busy_o     ( arb_busy   ),
    .mem_req_o  ( mem_req_o  ),
    .mem_data_o ( mem_data_o )
  );

  flush_seq i_flush_seq (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .enable_i      ( enable_i    ),
    .flush_i       ( flush_i     ),
    .mshr_vld_i    ( mshr_vld    ),
    .stores_idle_i ( stores_idle ),
    .arb_busy_i    ( arb_busy    ),
    .hold_o        ( hold        ),
    .sweeping_o    ( sweeping    ),
    .cl_wr_o       ( fl_cl_wr    ),
    .flush_ack_o   ( flush_ack_o ),
    .cache_en_o    ( cache_en_o  )
  );

  // the sweep owns the write port, refills otherwise
  assign wr_cl_o         = sweeping ? fl_cl_wr : ld_cl_wr;

  // store port sits on top of the read ports
  assign miss_ack_o      = {st_ack, ld_ack};
  assign miss_rtrn_vld_o = {st_rtrn_vld, ld_rtrn_vld};

endmodule

//--- sim/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter realtime Period      = 10ns,
  parameter int      ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(Period / 2) clk_o = ~clk_o;
    end
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- sim/tb_miss_unit.sv
`timescale 1ns/100ps

module tb_miss_unit import miss_cfg_pkg::*; import miss_msg_pkg::*; #(
  parameter int unsigned NumPorts = 3
);

  localparam int NumOps        = 60;
  localparam int TimeoutCycles = 3 * NUM_SETS + 40 * NumOps;
  localparam int StPort        = NumPorts - 1;

  logic                       clk_i, rst_ni;
  logic                       enable_i, flush_i, flush_ack_o, cache_en_o, miss_o;
  logic      [NumPorts-1:0]   miss_req_i, miss_ack_o, miss_rtrn_vld_o;
  miss_req_t [NumPorts-1:0]   miss_i;
  logic [TID_WIDTH-1:0]       miss_rtrn_id_o;
  cl_wr_t                     wr_cl_o;
  logic                       mem_req_o, mem_ack_i, mem_rtrn_vld_i;
  mem_req_t                   mem_data_o;
  mem_rtrn_t                  mem_rtrn_i;

  integer                     seed;
  int                         cycles, issued, flushes, flush_acks, sweep_idx, en_low_cnt;
  logic                       in_sweep, sweep_exp, flush_pend, flush_done, en_done, exp_en;
  // per port stimulus
  logic                       port_act [NumPorts];
  miss_req_t                  port_req [NumPorts];
  // reference copy of the MSHR
  logic                       mshr_v, mshr_nc, ld_pend;
  logic [PADDR_WIDTH-1:0]     mshr_paddr;
  logic [TID_WIDTH-1:0]       mshr_tid;
  logic [WAY_WIDTH-1:0]       mshr_way;
  int                         mshr_port, ld_due;
  // memory model, store acks leave in order
  logic [TID_WIDTH-1:0]       st_tid_q [$];
  int                         st_due_q [$];
  logic [TID_WIDTH-1:0]       last_st_tid;

  tb_clk_gen i_clk_gen (
    .clk_o  ( clk_i  ),
    .rst_no ( rst_ni )
  );

  dcache_miss_unit #(
    .NumPorts ( NumPorts )
  ) UUT (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .enable_i        ( enable_i        ),
    .flush_i         ( flush_i         ),
    .flush_ack_o     ( flush_ack_o     ),
    .cache_en_o      ( cache_en_o      ),
    .miss_o          ( miss_o          ),
    .miss_req_i      ( miss_req_i      ),
    .miss_i          ( miss_i          ),
    .miss_ack_o      ( miss_ack_o      ),
    .miss_rtrn_vld_o ( miss_rtrn_vld_o ),
    .miss_rtrn_id_o  ( miss_rtrn_id_o  ),
    .wr_cl_o         ( wr_cl_o         ),
    .mem_req_o       ( mem_req_o       ),
    .mem_data_o      ( mem_data_o      ),
    .mem_ack_i       ( mem_ack_i       ),
    .mem_rtrn_vld_i  ( mem_rtrn_vld_i  ),
    .mem_rtrn_i      ( mem_rtrn_i      )
  );

  ////////////////////
  // helpers
  ////////////////////

  task automatic report_failure(input string msg);
    $display("TEST FAILED");
    $fatal(1, "%s at %0t", msg, $time);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      report_failure("bit mismatch");
    end
  endtask

  task automatic check_tid(input string name, input logic [TID_WIDTH-1:0] got,
                           input logic [TID_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      report_failure("transaction id mismatch");
    end
  endtask

  task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      report_failure("memory request mismatch");
    end
  endtask

  task automatic check_cl_wr(input string name, input cl_wr_t got, input cl_wr_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      report_failure("cacheline write mismatch");
    end
  endtask

  function automatic int rand_below(input int n);
    rand_below = int'({$random(seed)} % 32'(n));
  endfunction

  // memory contents are a function of the line address
  function automatic logic [LINE_WIDTH-1:0] line_data(input logic [PADDR_WIDTH-1:0] a);
    line_data = {a, 8'hc3, ~a, 8'h3c};
  endfunction

  // first cleared valid bit counting up from way 0
  function automatic logic [WAY_WIDTH-1:0] lowest_free(input logic [SET_ASSOC-1:0] v);
    logic found;
    found       = 1'b0;
    lowest_free = '0;
    for (int w = 0; w < SET_ASSOC; w++) begin
      if (!v[w] && !found) begin
        found       = 1'b1;
        lowest_free = WAY_WIDTH'(w);
      end
    end
  endfunction

  // small pool of lines, three tags on two sets, so collisions are common
  function automatic miss_req_t new_miss();
    int k;
    k = rand_below(6);
    new_miss.paddr    = (PADDR_WIDTH'(k % 3 + 1) << 12) |
                        (PADDR_WIDTH'(k / 3 + 5) << OFFSET_WIDTH) |
                        PADDR_WIDTH'($random(seed) & 8);
    new_miss.size     = 3'd3;
    new_miss.tid      = TID_WIDTH'($random(seed));
    new_miss.nc       = (rand_below(8) == 0);
    new_miss.wdata    = {$random(seed), $random(seed)};
    new_miss.vld_bits = (rand_below(4) == 0) ? '1 : SET_ASSOC'($random(seed));
  endfunction

  ////////////////////
  // checks on the rising edge
  ////////////////////

  task automatic check_cycle();
    mem_req_t exp_req;
    cl_wr_t   exp_wr;
    logic     acc, ld_rsp, st_rsp, rtrn_exp;
    int       ap, n_ack;
    acc    = mem_req_o && mem_ack_i;
    ld_rsp = mem_rtrn_vld_i && (mem_rtrn_i.rtype == RTRN_LOAD_ACK);
    st_rsp = mem_rtrn_vld_i && (mem_rtrn_i.rtype == RTRN_STORE_ACK);
    ap     = -1;
    n_ack  = 0;
    check_bit("cache_en_o", cache_en_o, exp_en);
    // acknowledges seen on the DUT output
    if (flush_ack_o) flush_acks++;

    // a write to all ways marks the first set of a sweep
    if (!in_sweep && wr_cl_o.vld && (&wr_cl_o.we)) begin
      if (!sweep_exp) report_failure("sweep started without reset, flush or enable");
      if (mshr_v || st_tid_q.size() != 0) report_failure("sweep started with misses in flight");
      in_sweep  = 1'b1;
      sweep_idx = 0;
    end

    if (in_sweep) begin
      check_bit("mem_req_o", mem_req_o, 1'b0);
      exp_wr     = '0;
      exp_wr.vld = 1'b1;
      exp_wr.we  = '1;
      exp_wr.idx = INDEX_WIDTH'(sweep_idx);
      check_cl_wr("wr_cl_o", wr_cl_o, exp_wr);
      check_bit("flush_ack_o", flush_ack_o, (sweep_idx == NUM_SETS - 1) && flush_pend);
    end else begin
      check_bit("flush_ack_o", flush_ack_o, 1'b0);
      if (ld_rsp && !mshr_nc) begin
        exp_wr          = '0;
        exp_wr.vld      = 1'b1;
        exp_wr.we       = SET_ASSOC'(1) << mshr_way;
        exp_wr.idx      = mshr_paddr[OFFSET_WIDTH +: INDEX_WIDTH];
        exp_wr.tag      = mshr_paddr[PADDR_WIDTH-1 -: TAG_WIDTH];
        exp_wr.data     = line_data(mshr_paddr);
        exp_wr.vld_bits = exp_wr.we;
        check_cl_wr("wr_cl_o", wr_cl_o, exp_wr);
      end else begin
        check_bit("wr_cl_o.vld", wr_cl_o.vld, 1'b0);
      end
    end

    // responses go back to the port that asked
    for (int p = 0; p < NumPorts; p++) begin
      rtrn_exp = (ld_rsp && p == mshr_port) || (st_rsp && p == StPort);
      check_bit($sformatf("miss_rtrn_vld_o[%0d]", p), miss_rtrn_vld_o[p], rtrn_exp);
    end
    if (st_rsp) check_tid("miss_rtrn_id_o", miss_rtrn_id_o, last_st_tid);

    for (int p = 0; p < NumPorts; p++) begin
      if (miss_ack_o[p]) begin
        n_ack++;
        ap = p;
      end
    end
    if (!acc) begin
      if (n_ack != 0) report_failure("port acknowledged without a memory acknowledge");
      check_bit("miss_o", miss_o, 1'b0);
    end else begin
      if (n_ack != 1) report_failure("memory acknowledge did not pick exactly one port");
      if (!port_act[ap]) report_failure("acknowledge for a port with no request");
      exp_req.paddr = port_req[ap].paddr;
      exp_req.size  = port_req[ap].size;
      exp_req.tid   = port_req[ap].tid;
      exp_req.nc    = port_req[ap].nc;
      if (ap == StPort) begin
        exp_req.rtype = MEM_STORE_REQ;
        exp_req.way   = '0;
        exp_req.data  = port_req[ap].wdata;
        if (mshr_v && !ld_rsp && port_req[ap].paddr[PADDR_WIDTH-1:OFFSET_WIDTH] ==
            mshr_paddr[PADDR_WIDTH-1:OFFSET_WIDTH]) begin
          report_failure("store sent to the line of an outstanding load");
        end
        check_bit("miss_o", miss_o, 1'b0);
      end else begin
        exp_req.rtype = MEM_LOAD_REQ;
        exp_req.data  = '0;
        // full set lets the DUT pick any way
        exp_req.way   = (&port_req[ap].vld_bits) ? mem_data_o.way :
                        lowest_free(port_req[ap].vld_bits);
        if (mshr_v && !ld_rsp) report_failure("second load sent while a load is outstanding");
        check_bit("miss_o", miss_o, !port_req[ap].nc);
      end
      check_mem_req("mem_data_o", mem_data_o, exp_req);
    end

    // model update
    if (in_sweep) begin
      if (sweep_idx == NUM_SETS - 1) begin
        exp_en     = enable_i;
        in_sweep   = 1'b0;
        sweep_exp  = 1'b0;
        flush_pend = 1'b0;
      end else begin
        sweep_idx++;
        exp_en = exp_en & enable_i;
      end
    end else begin
      exp_en = exp_en & enable_i;
    end
    if (ld_rsp) mshr_v = 1'b0;
    if (acc) begin
      port_act[ap] = 1'b0;
      if (ap == StPort) begin
        st_tid_q.push_back(port_req[ap].tid);
        st_due_q.push_back(cycles + 1 + rand_below(6));
      end else begin
        mshr_v     = 1'b1;
        mshr_nc    = port_req[ap].nc;
        mshr_paddr = port_req[ap].paddr;
        mshr_tid   = port_req[ap].tid;
        mshr_way   = mem_data_o.way;
        mshr_port  = ap;
        ld_pend    = 1'b1;
        ld_due     = cycles + 1 + rand_below(6);
      end
    end
  endtask

  ////////////////////
  // stimulus on the falling edge
  ////////////////////

  task automatic drive_cycle();
    mem_ack_i      = (rand_below(4) != 0);
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_i     = '0;
    flush_i        = 1'b0;
    if (ld_pend && cycles >= ld_due) begin
      mem_rtrn_vld_i   = 1'b1;
      mem_rtrn_i.rtype = RTRN_LOAD_ACK;
      mem_rtrn_i.tid   = mshr_tid;
      mem_rtrn_i.data  = line_data(mshr_paddr);
      ld_pend          = 1'b0;
    end else if (st_tid_q.size() != 0 && cycles >= st_due_q[0]) begin
      last_st_tid      = st_tid_q.pop_front();
      mem_rtrn_vld_i   = 1'b1;
      mem_rtrn_i.rtype = RTRN_STORE_ACK;
      mem_rtrn_i.tid   = last_st_tid;
      void'(st_due_q.pop_front());
    end

    // one flush, later one disable and enable
    if (en_low_cnt > 0) begin
      en_low_cnt--;
      if (en_low_cnt == 0) begin
        enable_i  = 1'b1;
        sweep_exp = 1'b1;
        en_done   = 1'b1;
      end
    end else if (!flush_done && !sweep_exp && issued >= NumOps / 3) begin
      flush_i    = 1'b1;
      flush_pend = 1'b1;
      sweep_exp  = 1'b1;
      flush_done = 1'b1;
      flushes++;
    end else if (!en_done && !sweep_exp && exp_en && issued >= 2 * NumOps / 3) begin
      enable_i   = 1'b0;
      en_low_cnt = 3;
    end

    for (int p = 0; p < NumPorts; p++) begin
      if (!port_act[p] && issued < NumOps && rand_below(3) == 0) begin
        port_act[p] = 1'b1;
        port_req[p] = new_miss();
        issued++;
      end
      miss_req_i[p] = port_act[p];
      miss_i[p]     = port_req[p];
    end
  endtask

  function automatic logic all_done();
    all_done = (issued >= NumOps) && !mshr_v && !ld_pend && (st_tid_q.size() == 0) &&
               !sweep_exp && !in_sweep && flush_done && en_done;
    for (int p = 0; p < NumPorts; p++) begin
      if (port_act[p]) all_done = 1'b0;
    end
  endfunction

  initial begin
    seed           = 32'h457b59be;
    enable_i       = 1'b1;
    flush_i        = 1'b0;
    miss_req_i     = '0;
    miss_i         = '0;
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_i     = '0;
    cycles         = 0;
    issued         = 0;
    flushes        = 0;
    flush_acks     = 0;
    sweep_idx      = 0;
    en_low_cnt     = 0;
    in_sweep       = 1'b0;
    // reset always begins with a sweep
    sweep_exp      = 1'b1;
    flush_pend     = 1'b0;
    flush_done     = 1'b0;
    en_done        = 1'b0;
    exp_en         = 1'b0;
    mshr_v         = 1'b0;
    mshr_nc        = 1'b0;
    ld_pend        = 1'b0;
    mshr_paddr     = '0;
    mshr_tid       = '0;
    mshr_way       = '0;
    mshr_port      = -1;
    ld_due         = 0;
    last_st_tid    = '0;
    for (int p = 0; p < NumPorts; p++) begin
      port_act[p] = 1'b0;
      port_req[p] = '0;
    end
    @(posedge rst_ni);
    while (!all_done()) begin
      @(posedge clk_i);
      check_cycle();
      @(negedge clk_i);
      drive_cycle();
      cycles++;
      if (cycles > TimeoutCycles) report_failure("timeout, operations did not complete");
    end
    if (flush_acks == flushes) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "flush acknowledged %0d times for %0d flushes", flush_acks, flushes);
    end
  end

endmodule

//--- tb.f
src/miss_cfg_pkg.sv
src/miss_msg_pkg.sv
src/refill_way_sel.sv
src/load_mshr.sv
src/store_path.sv
src/mem_req_arbiter.sv
src/flush_seq.sv
src/dcache_miss_unit.sv
sim/tb_clk_gen.sv
sim/tb_miss_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_miss_unit
BUILD_DIR ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert -j 0
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
